// ==== pea_mem_pkg.sv ====
//==========================================================
// Memory side types and the records passed between stages
// Import before the configuration package
//==========================================================
package pea_mem_pkg;

    localparam int NZF_W = 4;   // Flag bits per FRAM word

    // Index widths shared with the layer configuration
    localparam int LEN_W = 10;
    localparam int GRP_W = 6;
    localparam int ICH_W = 8;
    localparam int TAP_W = 3;

    typedef logic [11:0]      fram_addr_t;
    typedef logic [11:0]      aram_addr_t;
    typedef logic [12:0]      wram_addr_t;
    typedef logic [NZF_W-1:0] nzf_t;
    typedef logic [7:0]       act_data_t;
    typedef logic [7:0]       wei_data_t;

    // One outstanding FRAM read
    typedef struct packed {
        logic [LEN_W-1:0] pixel;
        logic [GRP_W-1:0] grp;
        logic             last;
    } flag_tag_t;

    typedef struct packed {
        logic [LEN_W-1:0] pixel;
        logic [ICH_W-1:0] ich;
        logic             last;
    } chan_job_t;

    typedef struct packed {
        act_data_t  dat;
        aram_addr_t inf;
        logic       lst;
    } act_beat_t;

    typedef struct packed {
        wei_data_t        dat;
        logic [TAP_W-1:0] inf;
        logic             lst;
    } wei_beat_t;

endpackage

// ==== pea_cfg_pkg.sv ====
//==========================================================
// Layer configuration for one pass of the data generator
//==========================================================
package pea_cfg_pkg;

    import pea_mem_pkg::*;

    typedef logic [GRP_W-1:0] grp_t;   // Group of four input channels
    typedef logic [ICH_W-1:0] ich_t;
    typedef logic [LEN_W-1:0] len_t;
    typedef logic [TAP_W-1:0] tap_t;

    // Counts are stored minus one
    typedef struct packed {
        logic       flag_ena;
        grp_t       grp_last;
        len_t       len_last;
        tap_t       tap_last;
        wram_addr_t wram_base;
    } pea_cfg_t;

endpackage

// ==== sync_fifo.sv ====
`timescale 1ns/100ps
//==========================================================
// First-word-fall-through FIFO on a register array
// Any depth of 2 or more, occupancy on count_o
//==========================================================
module sync_fifo #(
    parameter int  W     = 8,
    parameter int  DEPTH = 4,
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1,
    localparam int CW    = $clog2(DEPTH + 1)
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          wr_i,
    input  logic [W-1:0]  din_i,
    input  logic          rd_i,
    output logic [W-1:0]  dout_o,
    output logic          empty_o,
    output logic          full_o,
    output logic [CW-1:0] count_o
);
    logic [W-1:0]  mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            if (wr_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_i) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count_o <= count_o + CW'(wr_i) - CW'(rd_i);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_ptr] <= din_i;
        end
    end

    assign dout_o  = mem[rd_ptr];   // Head entry always visible
    assign empty_o = (count_o == '0);
    assign full_o  = (count_o == CW'(DEPTH));

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr_i |-> !full_o);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd_i |-> !empty_o);

endmodule

// ==== pea_seq_ctrl.sv ====
`timescale 1ns/100ps
//==========================================================
// Pass sequencer: config handshake, FRAM address scan over
// pixels and channel groups, end-of-pass detection
//==========================================================
module pea_seq_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cfg_vld_i,
    input  pea_cfg_pkg::pea_cfg_t  cfg_i,
    output logic                   cfg_rdy_o,
    output logic                   idle_o,
    output pea_cfg_pkg::pea_cfg_t  cfg_o,
    output logic                   fram_add_vld_o,
    input  logic                   fram_add_rdy_i,
    output pea_mem_pkg::fram_addr_t fram_add_o,
    output logic                   tag_push_o,
    output pea_mem_pkg::flag_tag_t tag_o,
    input  logic                   flag_room_i,
    input  logic                   scan_busy_i,
    input  logic                   act_busy_i,
    input  logic                   wei_busy_i
);
    import pea_cfg_pkg::*;
    import pea_mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DRAIN,
        DONE
    } state_t;

    state_t     state;
    state_t     state_nxt;
    pea_cfg_t   cfg_q;
    grp_t       grp_cnt;
    len_t       pix_cnt;
    fram_addr_t fram_add;
    logic       cfg_hs;
    logic       add_hs;
    logic       last_word;

    assign cfg_hs    = cfg_vld_i && cfg_rdy_o;
    assign add_hs    = fram_add_vld_o && fram_add_rdy_i;
    assign last_word = (grp_cnt == cfg_q.grp_last) && (pix_cnt == cfg_q.len_last);

    //==========================================================
    // FSM
    //==========================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (cfg_hs) state_nxt = SCAN;
            end
            SCAN: begin
                if (add_hs && last_word) state_nxt = DRAIN;
            end
            DRAIN: begin
                if (!scan_busy_i) state_nxt = DONE;   // All flag words turned into jobs
            end
            DONE: begin
                if (!(scan_busy_i || act_busy_i || wei_busy_i)) state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_hs) begin
            cfg_q <= cfg_i;
        end
    end

    //==========================================================
    // Scan counters
    //==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grp_cnt  <= '0;
            pix_cnt  <= '0;
            fram_add <= '0;
        end else if (cfg_hs) begin
            grp_cnt  <= '0;
            pix_cnt  <= '0;
            fram_add <= '0;
        end else if (add_hs) begin
            // Groups inner, pixels outer, so the address simply counts up
            fram_add <= fram_add + 1'b1;
            if (grp_cnt == cfg_q.grp_last) begin
                grp_cnt <= '0;
                pix_cnt <= pix_cnt + 1'b1;
            end else begin
                grp_cnt <= grp_cnt + 1'b1;
            end
        end
    end

    assign cfg_rdy_o      = (state == IDLE);
    assign idle_o         = cfg_rdy_o;
    assign cfg_o          = cfg_q;
    assign fram_add_vld_o = (state == SCAN) && flag_room_i;   // Room only grows while held
    assign fram_add_o     = fram_add;
    assign tag_push_o     = add_hs;
    assign tag_o          = '{pixel: pix_cnt, grp: grp_cnt, last: last_word};

    // New configuration only taken once every stage has drained
    a_cfg_stable: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_hs |-> !(scan_busy_i || act_busy_i || wei_busy_i));

endmodule

// ==== nzf_scan.sv ====
`timescale 1ns/100ps
//==========================================================
// Zero skipping: pairs FRAM words with their tags and emits
// one channel job per set flag bit, lowest bit first
//==========================================================
module nzf_scan #(
    parameter int OUT_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pea_cfg_pkg::pea_cfg_t  cfg_i,
    input  logic                   tag_push_i,
    input  pea_mem_pkg::flag_tag_t tag_i,
    output logic                   flag_room_o,
    input  logic                   fram_dat_vld_i,
    output logic                   fram_dat_rdy_o,
    input  pea_mem_pkg::nzf_t      fram_dat_i,
    input  logic                   act_job_rdy_i,
    input  logic                   wei_job_rdy_i,
    output logic                   job_vld_o,
    output pea_mem_pkg::chan_job_t job_o,
    output logic                   busy_o
);
    import pea_mem_pkg::*;

    localparam int IDX_W = $clog2(NZF_W);

    flag_tag_t        tag;
    nzf_t             flag_raw;
    nzf_t             flag_word;
    nzf_t             mask;
    nzf_t             rem;
    nzf_t             pick;
    logic [IDX_W-1:0] bit_idx;
    logic             tag_empty;
    logic             tag_full;
    logic             flag_empty;
    logic             flag_full;
    logic             word_pop;
    logic             rest_none;

    sync_fifo #(.W($bits(flag_tag_t)), .DEPTH(OUT_DEPTH)) u_tag_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_i(tag_push_i), .din_i(tag_i), .rd_i(word_pop), .dout_o(tag),
        .empty_o(tag_empty), .full_o(tag_full), .count_o()
    );

    sync_fifo #(.W(NZF_W), .DEPTH(OUT_DEPTH)) u_flag_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_i(fram_dat_vld_i && fram_dat_rdy_o), .din_i(fram_dat_i),
        .rd_i(word_pop), .dout_o(flag_raw),
        .empty_o(flag_empty), .full_o(flag_full), .count_o()
    );

    // Dense mode sets every bit, bit 0 forced on the final word
    assign flag_word = flag_raw | {NZF_W{!cfg_i.flag_ena}} | nzf_t'(tag.last);
    assign rem       = flag_word & ~mask & {NZF_W{!flag_empty}};

    // Lowest remaining bit
    always_comb begin
        bit_idx = '0;
        for (int i = NZF_W - 1; i >= 0; i--) begin
            if (rem[i]) begin
                bit_idx = IDX_W'(i);
            end
        end
    end

    assign pick      = nzf_t'(1) << bit_idx;
    assign rest_none = ((rem & ~pick) == '0);
    assign job_vld_o = (rem != '0) && act_job_rdy_i && wei_job_rdy_i;
    assign word_pop  = !flag_empty && ((rem == '0) || (job_vld_o && rest_none));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask <= '0;
        end else if (word_pop) begin
            mask <= '0;
        end else if (job_vld_o) begin
            mask <= mask | pick;   // Bits already issued
        end
    end

    assign job_o = '{pixel: tag.pixel, ich: {tag.grp, bit_idx}, last: tag.last && rest_none};

    assign flag_room_o    = !tag_full;
    assign fram_dat_rdy_o = !tag_empty && !flag_full;   // Only while a read is outstanding
    assign busy_o         = !tag_empty;   // Every held word has a tag

endmodule

// ==== act_fetch.sv ====
`timescale 1ns/100ps
//==========================================================
// Activation fetch: one ARAM read per job, returned bytes
// tagged with their address and sent out as ACT beats
//==========================================================
module act_fetch #(
    parameter int JOB_DEPTH = 4,
    parameter int OUT_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pea_cfg_pkg::pea_cfg_t   cfg_i,
    input  logic                    job_vld_i,
    input  pea_mem_pkg::chan_job_t  job_i,
    output logic                    job_rdy_o,
    output logic                    aram_add_vld_o,
    input  logic                    aram_add_rdy_i,
    output pea_mem_pkg::aram_addr_t aram_add_o,
    input  logic                    aram_dat_vld_i,
    output logic                    aram_dat_rdy_o,
    input  pea_mem_pkg::act_data_t  aram_dat_i,
    output logic                    act_vld_o,
    input  logic                    act_rdy_i,
    output pea_mem_pkg::act_beat_t  act_o,
    output logic                    busy_o
);
    import pea_cfg_pkg::*;
    import pea_mem_pkg::*;

    localparam int CW = $clog2(OUT_DEPTH + 1);

    typedef struct packed {
        aram_addr_t inf;
        logic       lst;
    } act_tag_t;

    chan_job_t     job;
    act_tag_t      req_tag;
    act_tag_t      ret_tag;
    logic          job_empty;
    logic          job_full;
    logic          tag_empty;
    logic          out_empty;
    logic [CW-1:0] tag_cnt;
    logic [CW-1:0] out_cnt;
    logic          add_hs;
    logic          dat_hs;

    sync_fifo #(.W($bits(chan_job_t)), .DEPTH(JOB_DEPTH)) u_job_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_i(job_vld_i && job_rdy_o), .din_i(job_i), .rd_i(add_hs), .dout_o(job),
        .empty_o(job_empty), .full_o(job_full), .count_o()
    );

    assign aram_add_o = aram_addr_t'(job.pixel)
                      + aram_addr_t'(job.ich) * (aram_addr_t'(cfg_i.len_last) + 1'b1);

    assign aram_add_vld_o = !job_empty && ((tag_cnt + out_cnt) < CW'(OUT_DEPTH));
    assign add_hs         = aram_add_vld_o && aram_add_rdy_i;
    assign req_tag        = '{inf: aram_add_o, lst: job.last};

    sync_fifo #(.W($bits(act_tag_t)), .DEPTH(OUT_DEPTH)) u_tag_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_i(add_hs), .din_i(req_tag), .rd_i(dat_hs), .dout_o(ret_tag),
        .empty_o(tag_empty), .full_o(), .count_o(tag_cnt)
    );

    assign aram_dat_rdy_o = !tag_empty;
    assign dat_hs         = aram_dat_vld_i && aram_dat_rdy_o;

    sync_fifo #(.W($bits(act_beat_t)), .DEPTH(OUT_DEPTH)) u_out_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_i(dat_hs),
        .din_i(act_beat_t'{dat: aram_dat_i, inf: ret_tag.inf, lst: ret_tag.lst}),
        .rd_i(act_vld_o && act_rdy_i), .dout_o(act_o),
        .empty_o(out_empty), .full_o(), .count_o(out_cnt)
    );

    assign job_rdy_o = !job_full;
    assign act_vld_o = !out_empty;
    assign busy_o    = !(job_empty && tag_empty && out_empty);

endmodule

// ==== wei_fetch.sv ====
`timescale 1ns/100ps
//==========================================================
// Weight fetch: expands each job into a burst of tap reads
// from WRAM and sends the weights out as WEI beats
//==========================================================
module wei_fetch #(
    parameter int JOB_DEPTH = 4,
    parameter int OUT_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pea_cfg_pkg::pea_cfg_t   cfg_i,
    input  logic                    job_vld_i,
    input  pea_mem_pkg::chan_job_t  job_i,
    output logic                    job_rdy_o,
    output logic                    wram_add_vld_o,
    input  logic                    wram_add_rdy_i,
    output pea_mem_pkg::wram_addr_t wram_add_o,
    input  logic                    wram_dat_vld_i,
    output logic                    wram_dat_rdy_o,
    input  pea_mem_pkg::wei_data_t  wram_dat_i,
    output logic                    wei_vld_o,
    input  logic                    wei_rdy_i,
    output pea_mem_pkg::wei_beat_t  wei_o,
    output logic                    busy_o
);
    import pea_cfg_pkg::*;
    import pea_mem_pkg::*;

    localparam int CW = $clog2(OUT_DEPTH + 1);

    typedef struct packed {
        tap_t inf;
        logic lst;
    } wei_tag_t;

    chan_job_t     job;
    wei_tag_t      req_tag;
    wei_tag_t      ret_tag;
    tap_t          tap_cnt;
    logic          tap_end;
    logic          job_empty;
    logic          job_full;
    logic          tag_empty;
    logic          out_empty;
    logic [CW-1:0] tag_cnt;
    logic [CW-1:0] out_cnt;
    logic          add_hs;
    logic          dat_hs;

    sync_fifo #(.W($bits(chan_job_t)), .DEPTH(JOB_DEPTH)) u_job_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_i(job_vld_i && job_rdy_o), .din_i(job_i), .rd_i(add_hs && tap_end), .dout_o(job),
        .empty_o(job_empty), .full_o(job_full), .count_o()
    );

    //==========================================================
    // Tap expansion and address issue
    //==========================================================
    assign tap_end = (tap_cnt == cfg_i.tap_last);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap_cnt <= '0;
        end else if (add_hs) begin
            tap_cnt <= tap_end ? '0 : tap_cnt + 1'b1;
        end
    end

    assign wram_add_o = cfg_i.wram_base
                      + wram_addr_t'(job.ich) * (wram_addr_t'(cfg_i.tap_last) + 1'b1)
                      + wram_addr_t'(tap_cnt);

    // Output space reserved for every read in flight
    assign wram_add_vld_o = !job_empty && ((tag_cnt + out_cnt) < CW'(OUT_DEPTH));
    assign add_hs         = wram_add_vld_o && wram_add_rdy_i;
    assign req_tag        = '{inf: tap_cnt, lst: tap_end};

    sync_fifo #(.W($bits(wei_tag_t)), .DEPTH(OUT_DEPTH)) u_tag_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_i(add_hs), .din_i(req_tag), .rd_i(dat_hs), .dout_o(ret_tag),
        .empty_o(tag_empty), .full_o(), .count_o(tag_cnt)
    );

    //==========================================================
    // Return path
    //==========================================================
    assign wram_dat_rdy_o = !tag_empty;
    assign dat_hs         = wram_dat_vld_i && wram_dat_rdy_o;

    sync_fifo #(.W($bits(wei_beat_t)), .DEPTH(OUT_DEPTH)) u_out_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_i(dat_hs),
        .din_i(wei_beat_t'{dat: wram_dat_i, inf: ret_tag.inf, lst: ret_tag.lst}),
        .rd_i(wei_vld_o && wei_rdy_i), .dout_o(wei_o),
        .empty_o(out_empty), .full_o(), .count_o(out_cnt)
    );

    assign job_rdy_o = !job_full;
    assign wei_vld_o = !out_empty;
    assign busy_o    = !(job_empty && tag_empty && out_empty);

endmodule

// ==== pea_dat_gen_top.sv ====
`timescale 1ns/100ps
//==========================================================
// PE array data generator for a 1-D convolution layer
// Connects the sequencer and stages to FRAM, ARAM and WRAM
//==========================================================
module pea_dat_gen_top #(
    parameter int JOB_DEPTH = 4,
    parameter int OUT_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_vld_i,
    input  pea_cfg_pkg::pea_cfg_t   cfg_i,
    output logic                    cfg_rdy_o,
    output logic                    idle_o,
    output logic                    fram_add_vld_o,
    input  logic                    fram_add_rdy_i,
    output pea_mem_pkg::fram_addr_t fram_add_o,
    input  logic                    fram_dat_vld_i,
    output logic                    fram_dat_rdy_o,
    input  pea_mem_pkg::nzf_t       fram_dat_i,
    output logic                    aram_add_vld_o,
    input  logic                    aram_add_rdy_i,
    output pea_mem_pkg::aram_addr_t aram_add_o,
    input  logic                    aram_dat_vld_i,
    output logic                    aram_dat_rdy_o,
    input  pea_mem_pkg::act_data_t  aram_dat_i,
    output logic                    wram_add_vld_o,
    input  logic                    wram_add_rdy_i,
    output pea_mem_pkg::wram_addr_t wram_add_o,
    input  logic                    wram_dat_vld_i,
    output logic                    wram_dat_rdy_o,
    input  pea_mem_pkg::wei_data_t  wram_dat_i,
    output logic                    act_vld_o,
    input  logic                    act_rdy_i,
    output pea_mem_pkg::act_beat_t  act_o,
    output logic                    wei_vld_o,
    input  logic                    wei_rdy_i,
    output pea_mem_pkg::wei_beat_t  wei_o
);
    import pea_cfg_pkg::*;
    import pea_mem_pkg::*;

    pea_cfg_t  cfg;
    logic      tag_push;
    flag_tag_t tag;
    logic      flag_room;
    logic      job_vld;
    chan_job_t job;
    logic      act_job_rdy;
    logic      wei_job_rdy;
    logic      scan_busy;
    logic      act_busy;
    logic      wei_busy;

    pea_seq_ctrl u_seq_ctrl (
        .clk(clk), .rst_n(rst_n),
        .cfg_vld_i(cfg_vld_i), .cfg_i(cfg_i), .cfg_rdy_o(cfg_rdy_o), .idle_o(idle_o),
        .cfg_o(cfg),
        .fram_add_vld_o(fram_add_vld_o), .fram_add_rdy_i(fram_add_rdy_i),
        .fram_add_o(fram_add_o),
        .tag_push_o(tag_push), .tag_o(tag), .flag_room_i(flag_room),
        .scan_busy_i(scan_busy), .act_busy_i(act_busy), .wei_busy_i(wei_busy)
    );

    nzf_scan #(.OUT_DEPTH(OUT_DEPTH)) u_nzf_scan (
        .clk(clk), .rst_n(rst_n), .cfg_i(cfg),
        .tag_push_i(tag_push), .tag_i(tag), .flag_room_o(flag_room),
        .fram_dat_vld_i(fram_dat_vld_i), .fram_dat_rdy_o(fram_dat_rdy_o),
        .fram_dat_i(fram_dat_i),
        .act_job_rdy_i(act_job_rdy), .wei_job_rdy_i(wei_job_rdy),
        .job_vld_o(job_vld), .job_o(job), .busy_o(scan_busy)
    );

    act_fetch #(.JOB_DEPTH(JOB_DEPTH), .OUT_DEPTH(OUT_DEPTH)) u_act_fetch (
        .clk(clk), .rst_n(rst_n), .cfg_i(cfg),
        .job_vld_i(job_vld), .job_i(job), .job_rdy_o(act_job_rdy),
        .aram_add_vld_o(aram_add_vld_o), .aram_add_rdy_i(aram_add_rdy_i),
        .aram_add_o(aram_add_o),
        .aram_dat_vld_i(aram_dat_vld_i), .aram_dat_rdy_o(aram_dat_rdy_o),
        .aram_dat_i(aram_dat_i),
        .act_vld_o(act_vld_o), .act_rdy_i(act_rdy_i), .act_o(act_o), .busy_o(act_busy)
    );

    wei_fetch #(.JOB_DEPTH(JOB_DEPTH), .OUT_DEPTH(OUT_DEPTH)) u_wei_fetch (
        .clk(clk), .rst_n(rst_n), .cfg_i(cfg),
        .job_vld_i(job_vld), .job_i(job), .job_rdy_o(wei_job_rdy),
        .wram_add_vld_o(wram_add_vld_o), .wram_add_rdy_i(wram_add_rdy_i),
        .wram_add_o(wram_add_o),
        .wram_dat_vld_i(wram_dat_vld_i), .wram_dat_rdy_o(wram_dat_rdy_o),
        .wram_dat_i(wram_dat_i),
        .wei_vld_o(wei_vld_o), .wei_rdy_i(wei_rdy_i), .wei_o(wei_o), .busy_o(wei_busy)
    );

endmodule

// ==== tb_pea_dat_gen.sv ====
`timescale 1ns/100ps
//==========================================================
// Testbench for the PE array data generator: memory models,
// reference model and stream checks over several passes
//==========================================================
module tb_pea_dat_gen;
    import pea_cfg_pkg::*;
    import pea_mem_pkg::*;

    typedef struct {
        logic [7:0] dat;
        int         due;   // Cycle when the read data may show
    } rd_ent_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       cfg_vld_i, cfg_rdy_o, idle_o;
    pea_cfg_t   cfg_i;
    logic       fram_add_vld_o, fram_add_rdy_i, fram_dat_vld_i, fram_dat_rdy_o;
    fram_addr_t fram_add_o;
    nzf_t       fram_dat_i;
    logic       aram_add_vld_o, aram_add_rdy_i, aram_dat_vld_i, aram_dat_rdy_o;
    aram_addr_t aram_add_o;
    act_data_t  aram_dat_i;
    logic       wram_add_vld_o, wram_add_rdy_i, wram_dat_vld_i, wram_dat_rdy_o;
    wram_addr_t wram_add_o;
    wei_data_t  wram_dat_i;
    logic       act_vld_o, act_rdy_i, wei_vld_o, wei_rdy_i;
    act_beat_t  act_o;
    wei_beat_t  wei_o;

    integer     seed;
    int         cycle;
    int         act_seen;
    act_beat_t  act_last;
    logic       out_rand;
    nzf_t       fram [4096];
    act_data_t  aram [4096];
    wei_data_t  wram [8192];
    rd_ent_t    fram_q[$], aram_q[$], wram_q[$];
    act_beat_t  exp_act[$];
    wei_beat_t  exp_wei[$];
    logic       fram_a_fire, fram_d_fire, aram_a_fire, aram_d_fire, wram_a_fire, wram_d_fire;
    fram_addr_t fram_a;
    aram_addr_t aram_a;
    wram_addr_t wram_a;

    pea_dat_gen_top #(.JOB_DEPTH(2), .OUT_DEPTH(4)) dut (.*);

    always #5 clk = ~clk;

    function automatic logic rnd_ready();
        return ($random(seed) & 3) != 0;
    endfunction

    function automatic int latency();
        return 1 + int'(($random(seed) & 32'h7fff) % 3);
    endfunction

    function automatic pea_cfg_t make_cfg(input int ena, input int grp, input int len,
                                          input int tap, input int base);
        return '{flag_ena: ena[0], grp_last: grp_t'(grp), len_last: len_t'(len),
                 tap_last: tap_t'(tap), wram_base: wram_addr_t'(base)};
    endfunction

    //==========================================================
    // Reference model of both output streams
    //==========================================================
    function automatic void build_expected(input pea_cfg_t c);
        int   fa;
        int   ich;
        int   aa;
        int   wa;
        logic last;
        nzf_t w;
        exp_act.delete();
        exp_wei.delete();
        for (int p = 0; p <= int'(c.len_last); p++) begin
            for (int g = 0; g <= int'(c.grp_last); g++) begin
                fa   = p * (int'(c.grp_last) + 1) + g;
                last = (p == int'(c.len_last)) && (g == int'(c.grp_last));
                w    = fram[fa];
                if (!c.flag_ena) w = '1;   // Dense mode
                if (last) w[0] = 1'b1;
                for (int b = 0; b < NZF_W; b++) begin
                    if (w[b]) begin
                        ich = g * NZF_W + b;
                        aa  = p + ich * (int'(c.len_last) + 1);
                        exp_act.push_back(act_beat_t'{dat: aram[aa], inf: aram_addr_t'(aa),
                                                      lst: last && ((w >> (b + 1)) == '0)});
                        for (int t = 0; t <= int'(c.tap_last); t++) begin
                            wa = int'(c.wram_base) + ich * (int'(c.tap_last) + 1) + t;
                            exp_wei.push_back(wei_beat_t'{dat: wram[wa], inf: tap_t'(t),
                                                          lst: t == int'(c.tap_last)});
                        end
                    end
                end
            end
        end
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic want, input logic got);
        if (got !== want) fail_run($sformatf("Error: %s expected %h got %h", name, want, got));
    endtask

    task automatic check_aram_addr(input string name, input aram_addr_t want,
                                   input aram_addr_t got);
        if (got !== want) fail_run($sformatf("Error: %s expected %h got %h", name, want, got));
    endtask

    task automatic check_act(input act_beat_t got);
        act_beat_t want;
        if (exp_act.size() == 0) fail_run("An ACT beat came out when none was expected");
        want = exp_act.pop_front();
        if (got !== want) fail_run($sformatf("Error: act_o expected %h got %h", want, got));
    endtask

    task automatic check_wei(input wei_beat_t got);
        wei_beat_t want;
        if (exp_wei.size() == 0) fail_run("A WEI beat came out when none was expected");
        want = exp_wei.pop_front();
        if (got !== want) fail_run($sformatf("Error: wei_o expected %h got %h", want, got));
    endtask

    // Compare on every output transfer
    always @(negedge clk) begin
        if (rst_n && act_vld_o && act_rdy_i) begin
            check_act(act_o);
            act_seen++;
            act_last = act_o;
        end
        if (rst_n && wei_vld_o && wei_rdy_i) check_wei(wei_o);
    end

    //==========================================================
    // Memory models, in-order return after 1 to 3 cycles
    //==========================================================
    always begin
        @(negedge clk);
        fram_a_fire = fram_add_vld_o && fram_add_rdy_i;
        fram_d_fire = fram_dat_vld_i && fram_dat_rdy_o;
        aram_a_fire = aram_add_vld_o && aram_add_rdy_i;
        aram_d_fire = aram_dat_vld_i && aram_dat_rdy_o;
        wram_a_fire = wram_add_vld_o && wram_add_rdy_i;
        wram_d_fire = wram_dat_vld_i && wram_dat_rdy_o;
        fram_a = fram_add_o;
        aram_a = aram_add_o;
        wram_a = wram_add_o;
        @(posedge clk);
        #1;
        cycle++;
        if (fram_d_fire) void'(fram_q.pop_front());
        if (aram_d_fire) void'(aram_q.pop_front());
        if (wram_d_fire) void'(wram_q.pop_front());
        if (fram_a_fire) fram_q.push_back(rd_ent_t'{dat: 8'(fram[fram_a]), due: cycle + latency()});
        if (aram_a_fire) aram_q.push_back(rd_ent_t'{dat: aram[aram_a], due: cycle + latency()});
        if (wram_a_fire) wram_q.push_back(rd_ent_t'{dat: wram[wram_a], due: cycle + latency()});
        fram_dat_vld_i = 1'b0;
        if (fram_q.size() > 0 && fram_q[0].due <= cycle) begin
            fram_dat_vld_i = 1'b1;
            fram_dat_i     = nzf_t'(fram_q[0].dat);
        end
        aram_dat_vld_i = 1'b0;
        if (aram_q.size() > 0 && aram_q[0].due <= cycle) begin
            aram_dat_vld_i = 1'b1;
            aram_dat_i     = aram_q[0].dat;
        end
        wram_dat_vld_i = 1'b0;
        if (wram_q.size() > 0 && wram_q[0].due <= cycle) begin
            wram_dat_vld_i = 1'b1;
            wram_dat_i     = wram_q[0].dat;
        end
        fram_add_rdy_i = rnd_ready();
        aram_add_rdy_i = rnd_ready();
        wram_add_rdy_i = rnd_ready();
        act_rdy_i      = out_rand ? rnd_ready() : 1'b1;
        wei_rdy_i      = out_rand ? rnd_ready() : 1'b1;
    end

    task automatic fill_flags(input logic zero);
        for (int a = 0; a < 4096; a++) begin
            fram[a] = zero ? '0 : nzf_t'($random(seed));
        end
    endtask

    // One full pass, entered and left 1 ns after a rising edge
    task automatic run_pass(input pea_cfg_t c, input logic rand_out);
        int n;
        build_expected(c);
        act_seen  = 0;
        out_rand  = rand_out;
        cfg_i     = c;
        cfg_vld_i = 1'b1;
        n = 0;
        @(negedge clk);
        while (!cfg_rdy_o) begin
            n++;
            if (n > 100) fail_run("Timed out waiting for the DUT to accept a configuration");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        cfg_vld_i = 1'b0;
        check_bit("idle_o", 1'b0, idle_o);
        n = 0;
        while (!idle_o) begin
            @(negedge clk);
            n++;
            if (n > 20000) fail_run("Timed out waiting for the pass to finish");
        end
        if (exp_act.size() != 0 || exp_wei.size() != 0) begin
            fail_run($sformatf("Pass ended with %0d ACT and %0d WEI beats never sent",
                               exp_act.size(), exp_wei.size()));
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        seed           = 32'h0c65d41c;
        cycle          = 0;
        act_seen       = 0;
        out_rand       = 1'b0;
        rst_n          = 1'b0;
        cfg_vld_i      = 1'b0;
        cfg_i          = '0;
        fram_add_rdy_i = 1'b0;
        fram_dat_vld_i = 1'b0;
        fram_dat_i     = '0;
        aram_add_rdy_i = 1'b0;
        aram_dat_vld_i = 1'b0;
        aram_dat_i     = '0;
        wram_add_rdy_i = 1'b0;
        wram_dat_vld_i = 1'b0;
        wram_dat_i     = '0;
        act_rdy_i      = 1'b0;
        wei_rdy_i      = 1'b0;
        for (int a = 0; a < 4096; a++) begin
            aram[a] = act_data_t'(a) ^ act_data_t'(a >> 4);
        end
        for (int a = 0; a < 8192; a++) begin
            wram[a] = wei_data_t'(a) ^ wei_data_t'(a >> 8) ^ 8'h5a;
        end
        fill_flags(1'b1);
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_bit("idle_o", 1'b1, idle_o);
        check_bit("cfg_rdy_o", 1'b1, cfg_rdy_o);
        check_bit("fram_add_vld_o", 1'b0, fram_add_vld_o);
        check_bit("fram_dat_rdy_o", 1'b0, fram_dat_rdy_o);
        check_bit("aram_add_vld_o", 1'b0, aram_add_vld_o);
        check_bit("wram_add_vld_o", 1'b0, wram_add_vld_o);
        check_bit("act_vld_o", 1'b0, act_vld_o);
        check_bit("wei_vld_o", 1'b0, wei_vld_o);

        run_pass(make_cfg(0, 1, 5, 2, 0), 1'b0);      // Dense
        fill_flags(1'b0);
        run_pass(make_cfg(1, 2, 7, 3, 100), 1'b0);    // Sparse, random flags
        fill_flags(1'b1);
        run_pass(make_cfg(1, 1, 3, 1, 40), 1'b0);     // All-zero flags
        if (act_seen != 1) fail_run("All-zero flags did not give exactly one ACT beat");
        // Channel 4 at pixel 3, four pixels per channel
        check_aram_addr("act_o.inf", aram_addr_t'(3 + 4 * 4), act_last.inf);
        check_bit("act_o.lst", 1'b1, act_last.lst);
        fill_flags(1'b0);
        run_pass(make_cfg(1, 3, 9, 2, 512), 1'b1);    // Output back-pressure
        run_pass(make_cfg(0, 0, 4, 7, 1024), 1'b1);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
pea_mem_pkg.sv
pea_cfg_pkg.sv
sync_fifo.sv
pea_seq_ctrl.sv
nzf_scan.sv
act_fetch.sv
wei_fetch.sv
pea_dat_gen_top.sv
tb_pea_dat_gen.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_pea_dat_gen
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
